// File: Bender.yml
package:
  name: dma_burst_requester

sources:
  - files:
      - source/burst_pkg.sv
      - source/burst_cmd_if.sv
      - source/burst_address_generator.sv
      - source/burst_cmd_arbiter.sv
      - source/dma_burst_requester.sv
  - target: test
    files:
      - verification/dma_burst_requester_props.sv
      - verification/dma_burst_requester_tb.sv

// File: sim.f
source/burst_pkg.sv
source/burst_cmd_if.sv
source/burst_address_generator.sv
source/burst_cmd_arbiter.sv
source/dma_burst_requester.sv
verification/dma_burst_requester_props.sv
verification/dma_burst_requester_tb.sv

// File: source/burst_address_generator.sv
`timescale 1ns/100ps
`default_nettype none

module burst_address_generator import burst_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,

    input  wire addr_t  req_addr,
    input  wire size_t  req_size,
    input  wire len_t   req_max_len,
    input  wire logic   req_valid,
    output logic        req_ready,

    burst_cmd_if.source cmd
);

    // ---------------------------------------------------------
    // splitting stage
    // ---------------------------------------------------------
    gen_state_t state;
    addr_t      base_addr;
    addr_t      byte_offset;
    size_t      remain_size;
    len_t       max_len;

    logic       req_take;
    logic       out_free;
    logic       split_last;
    logic       split_move;
    addr_t      burst_bytes;
    len_t       last_len;

    // output register can take a burst this cycle
    assign out_free = !cmd.valid || cmd.ready;

    // stay busy until the final burst has left the output register
    assign req_ready = (state == idle) && !cmd.valid;
    assign req_take  = req_valid && req_ready;

    assign split_move = (state == split) && out_free;

    // final burst when what is left fits into one full burst
    assign split_last = ({1'b0, remain_size} + 33'(SIZE_OFFSET))
                     <= ({25'd0, max_len} + 33'(LEN_OFFSET));

    assign burst_bytes = (addr_t'(max_len) + addr_t'(LEN_OFFSET)) * addr_t'(BEAT_BYTES);

    // remaining beats re-encoded as a burst length
    assign last_len = len_t'(remain_size + size_t'(SIZE_OFFSET) - size_t'(LEN_OFFSET));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (req_take) begin
                        state <= split;
                    end
                end
                split: begin
                    if (out_free && split_last) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_take) begin
            base_addr   <= req_addr;
            byte_offset <= '0;
            remain_size <= req_size;
            max_len     <= req_max_len;
        end else if (split_move) begin
            byte_offset <= byte_offset + burst_bytes;
            remain_size <= remain_size - size_t'(max_len) - size_t'(LEN_OFFSET);
        end
    end

    // ---------------------------------------------------------
    // output register
    // ---------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd.valid <= 1'b0;
        end else if (out_free) begin
            cmd.valid <= (state == split);
        end
    end

    // payload holds while the arbiter stalls
    always_ff @(posedge clk) begin
        if (split_move) begin
            cmd.addr <= base_addr + byte_offset;
            cmd.len  <= split_last ? last_len : max_len;
            cmd.last <= split_last;
        end
    end

endmodule

`default_nettype wire

// File: source/burst_cmd_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module burst_cmd_arbiter import burst_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,

    burst_cmd_if.sink   ch0,
    burst_cmd_if.sink   ch1,

    output addr_t       cmd_addr,
    output len_t        cmd_len,
    output logic        cmd_last,
    output chan_t       cmd_channel,
    output logic        cmd_valid,
    input  wire logic   cmd_ready
);

    // ---------------------------------------------------------
    // grant selection
    // ---------------------------------------------------------
    arb_state_t              arb_state;
    logic [NUM_CHANNELS-1:0] ch_valid;
    logic [NUM_CHANNELS-1:0] grant;
    logic                    take;

    assign ch_valid = {ch1.valid, ch0.valid};

    // register empty or draining this cycle
    assign take = !cmd_valid || cmd_ready;

    always_comb begin
        grant = '0;
        if (&ch_valid) begin
            if (arb_state == prefer_ch0) begin
                grant[0] = 1'b1;
            end else begin
                grant[1] = 1'b1;
            end
        end else begin
            grant = ch_valid;
        end
    end

    // only the winner sees ready
    assign ch0.ready = take && grant[0];
    assign ch1.ready = take && grant[1];

    // flip only on a tie, the loser goes first next time
    always_ff @(posedge clk) begin
        if (reset) begin
            arb_state <= prefer_ch0;
        end else if (take && (&ch_valid)) begin
            arb_state <= (arb_state == prefer_ch0) ? prefer_ch1 : prefer_ch0;
        end
    end

    // ---------------------------------------------------------
    // command register
    // ---------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_valid <= 1'b0;
        end else if (take) begin
            cmd_valid <= |ch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take && (|ch_valid)) begin
            cmd_addr    <= grant[1] ? ch1.addr : ch0.addr;
            cmd_len     <= grant[1] ? ch1.len  : ch0.len;
            cmd_last    <= grant[1] ? ch1.last : ch0.last;
            cmd_channel <= chan_t'(grant[1]);
        end
    end

endmodule

`default_nettype wire

// File: source/burst_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

// one burst command with its valid/ready pair
interface burst_cmd_if import burst_pkg::*; ();

    addr_t addr;
    len_t  len;
    logic  last;
    logic  valid;
    logic  ready;

    // generator side
    modport source (
        output addr,
        output len,
        output last,
        output valid,
        input  ready
    );

    // arbiter side
    modport sink (
        input  addr,
        input  len,
        input  last,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// File: source/burst_pkg.sv
`default_nettype none

package burst_pkg;

    // ---------------------------------------------------------
    // widths with a meaning
    // ---------------------------------------------------------

    // byte address on the memory side
    typedef logic [31:0] addr_t;

    // transfer size in beats, stored as beats - SIZE_OFFSET
    typedef logic [31:0] size_t;

    // burst length, AXI style, stored as beats - LEN_OFFSET
    typedef logic [7:0] len_t;

    // which requester a command came from
    typedef logic [0:0] chan_t;

    // ---------------------------------------------------------
    // encodings and geometry
    // ---------------------------------------------------------

    localparam int SIZE_OFFSET  = 1;
    localparam int LEN_OFFSET   = 1;
    localparam int BEAT_BYTES   = 4;
    localparam int NUM_CHANNELS = 2;

    // ---------------------------------------------------------
    // state machines
    // ---------------------------------------------------------

    // splitting stage of one generator
    typedef enum logic {idle, split} gen_state_t;

    // round-robin pointer, names the channel that wins a tie
    typedef enum logic {prefer_ch0, prefer_ch1} arb_state_t;

endpackage

`default_nettype wire

// File: source/dma_burst_requester.sv
`timescale 1ns/100ps
`default_nettype none

module dma_burst_requester import burst_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,

    // channel 0 request
    input  wire addr_t  req0_addr,
    input  wire size_t  req0_size,
    input  wire len_t   req0_max_len,
    input  wire logic   req0_valid,
    output wire logic   req0_ready,

    // channel 1 request
    input  wire addr_t  req1_addr,
    input  wire size_t  req1_size,
    input  wire len_t   req1_max_len,
    input  wire logic   req1_valid,
    output wire logic   req1_ready,

    // shared memory command bus
    output wire addr_t  cmd_addr,
    output wire len_t   cmd_len,
    output wire logic   cmd_last,
    output wire chan_t  cmd_channel,
    output wire logic   cmd_valid,
    input  wire logic   cmd_ready
);

    // per channel burst streams into the arbiter
    burst_cmd_if ch_cmd [NUM_CHANNELS] ();

    burst_address_generator ch0_gen (
        .clk         (clk),
        .reset       (reset),
        .req_addr    (req0_addr),
        .req_size    (req0_size),
        .req_max_len (req0_max_len),
        .req_valid   (req0_valid),
        .req_ready   (req0_ready),
        .cmd         (ch_cmd[0])
    );

    burst_address_generator ch1_gen (
        .clk         (clk),
        .reset       (reset),
        .req_addr    (req1_addr),
        .req_size    (req1_size),
        .req_max_len (req1_max_len),
        .req_valid   (req1_valid),
        .req_ready   (req1_ready),
        .cmd         (ch_cmd[1])
    );

    burst_cmd_arbiter cmd_arb (
        .clk         (clk),
        .reset       (reset),
        .ch0         (ch_cmd[0]),
        .ch1         (ch_cmd[1]),
        .cmd_addr    (cmd_addr),
        .cmd_len     (cmd_len),
        .cmd_last    (cmd_last),
        .cmd_channel (cmd_channel),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready)
    );

endmodule

`default_nettype wire

// File: verification/dma_burst_requester_props.sv
`timescale 1ns/100ps
`default_nettype none

module dma_burst_requester_props import burst_pkg::*; (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire addr_t                   cmd_addr,
    input wire len_t                    cmd_len,
    input wire logic                    cmd_last,
    input wire chan_t                   cmd_channel,
    input wire logic                    cmd_valid,
    input wire logic                    cmd_ready,
    input wire logic [NUM_CHANNELS-1:0] ch_valid,
    input wire logic [NUM_CHANNELS-1:0] grant,
    input wire logic                    take
);

    int unsigned assert_failures = 0;

    logic  granted;
    chan_t grant_chan;
    logic  prev_grant_valid;
    chan_t prev_grant_chan;
    logic  prev_other_waiting;

    assign granted    = take && (|ch_valid);
    assign grant_chan = chan_t'(grant[1]);

    // last grant and whether the loser was waiting
    always_ff @(posedge clk) begin
        if (reset) begin
            prev_grant_valid <= 1'b0;
        end else if (granted) begin
            prev_grant_valid   <= 1'b1;
            prev_grant_chan    <= grant_chan;
            prev_other_waiting <= grant[1] ? ch_valid[0] : ch_valid[1];
        end
    end

    cmd_hold: assert property (@(posedge clk) disable iff (reset)
        (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd_addr) && $stable(cmd_len)
                                       && $stable(cmd_last) && $stable(cmd_channel)))
        else begin
            assert_failures++;
            $error("command bus changed while stalled");
        end

    reset_idle: assert property (@(posedge clk) reset |=> !cmd_valid)
        else begin
            assert_failures++;
            $error("cmd_valid high after a reset cycle");
        end

    alternate: assert property (@(posedge clk) disable iff (reset)
        (granted && prev_grant_valid && prev_other_waiting) |-> (grant_chan != prev_grant_chan))
        else begin
            assert_failures++;
            $error("channel granted twice while the other was waiting");
        end

endmodule

bind dma_burst_requester dma_burst_requester_props bus_props (
    .clk         (clk),
    .reset       (reset),
    .cmd_addr    (cmd_addr),
    .cmd_len     (cmd_len),
    .cmd_last    (cmd_last),
    .cmd_channel (cmd_channel),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .ch_valid    (cmd_arb.ch_valid),
    .grant       (cmd_arb.grant),
    .take        (cmd_arb.take)
);

`default_nettype wire

// File: verification/dma_burst_requester_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dma_burst_requester_tb import burst_pkg::*; ();

    localparam int NUM_ROWS   = 11;
    localparam int NUM_PHASES = 3;
    localparam int WAIT_LIMIT = 2000;

    typedef struct packed {
        addr_t addr;
        len_t  len;
        logic  last;
    } burst_t;

    typedef struct packed {
        int    phase;
        int    chan;
        addr_t addr;
        size_t size;
        len_t  max_len;
        int    bursts;
    } req_row_t;

    // phase, channel, start address, size, largest length, expected bursts
    req_row_t rows [NUM_ROWS] = '{
        '{0, 0, 32'h0000_1000,  31,   3,  8},
        '{0, 1, 32'h0002_0000,  24,   3,  7},
        '{1, 0, 32'h0000_4000,  63,  15,  4},
        '{1, 0, 32'h0000_5004,   2,   7,  1},
        '{1, 0, 32'h0000_6000,   9,   0, 10},
        '{1, 0, 32'h0000_7ffc,   0,   3,  1},
        '{1, 1, 32'h0003_0010,  36,   7,  5},
        '{1, 1, 32'h0003_8000,   7,   7,  1},
        '{1, 1, 32'h0003_9000, 299, 255,  2},
        '{2, 0, 32'h0000_0100,  11,   1,  6},
        '{2, 1, 32'h0000_0200,  15,   1,  8}
    };

    logic   clk = 1'b0;
    logic   reset;
    addr_t  req0_addr, req1_addr;
    size_t  req0_size, req1_size;
    len_t   req0_max_len, req1_max_len;
    logic   req0_valid, req1_valid, req0_ready, req1_ready;
    addr_t  cmd_addr;
    len_t   cmd_len;
    logic   cmd_last, cmd_valid, cmd_ready;
    chan_t  cmd_channel;

    logic [NUM_CHANNELS-1:0] req_valid_v, req_ready_v;

    // expected traffic per channel
    burst_t   exp_q [NUM_CHANNELS][$];
    int       exp_beats [NUM_CHANNELS][$];
    int       exp_bursts [NUM_CHANNELS][$];
    req_row_t row_q [NUM_CHANNELS][$];

    int          got_beats [NUM_CHANNELS];
    int          got_bursts [NUM_CHANNELS];
    int          accepted [NUM_CHANNELS];
    int          last_seen [NUM_CHANNELS];
    int          rows_per_chan [NUM_CHANNELS];
    int          error_count, timeout_count;
    logic [31:0] lcg_state;
    logic        bus_held, have_prev, alternate_on;
    chan_t       prev_chan;

    assign req_valid_v = {req1_valid, req0_valid};
    assign req_ready_v = {req1_ready, req0_ready};

    dma_burst_requester UUT (
        .clk(clk), .reset(reset),
        .req0_addr(req0_addr), .req0_size(req0_size), .req0_max_len(req0_max_len),
        .req0_valid(req0_valid), .req0_ready(req0_ready),
        .req1_addr(req1_addr), .req1_size(req1_size), .req1_max_len(req1_max_len),
        .req1_valid(req1_valid), .req1_ready(req1_ready),
        .cmd_addr(cmd_addr), .cmd_len(cmd_len), .cmd_last(cmd_last),
        .cmd_channel(cmd_channel), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // reference split of one request into bursts
    task automatic predict_bursts(input int ch, input req_row_t row);
        int    remain;
        int    max_beats;
        int    beats;
        addr_t addr;
        remain    = int'(row.size) + SIZE_OFFSET;
        max_beats = int'(row.max_len) + LEN_OFFSET;
        addr      = row.addr;
        exp_beats[ch].push_back(remain);
        exp_bursts[ch].push_back(row.bursts);
        while (remain > 0) begin
            beats = (remain < max_beats) ? remain : max_beats;
            exp_q[ch].push_back('{addr, len_t'(beats - LEN_OFFSET), beats == remain});
            addr   = addr + addr_t'(beats * BEAT_BYTES);
            remain = remain - beats;
        end
    endtask

    task automatic present_request(input int ch, input req_row_t row, input logic valid);
        if (ch == 0) begin
            req0_addr    <= row.addr;
            req0_size    <= row.size;
            req0_max_len <= row.max_len;
            req0_valid   <= valid;
        end else begin
            req1_addr    <= row.addr;
            req1_size    <= row.size;
            req1_max_len <= row.max_len;
            req1_valid   <= valid;
        end
    endtask

    task automatic drive_channel(input int ch);
        req_row_t row;
        int       waited;
        while (row_q[ch].size() > 0) begin
            row = row_q[ch].pop_front();
            @(posedge clk);
            predict_bursts(ch, row);
            present_request(ch, row, 1'b1);
            waited = 0;
            @(posedge clk);
            while (!req_ready_v[ch] && waited < WAIT_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (!req_ready_v[ch]) begin
                $display("timeout: channel %0d never accepted its request", ch);
                timeout_count++;
            end
            present_request(ch, row, 1'b0);
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((exp_q[0].size() > 0 || exp_q[1].size() > 0 || cmd_valid)
               && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q[0].size() > 0 || exp_q[1].size() > 0 || cmd_valid) begin
            $display("timeout: bursts still outstanding on the command bus");
            timeout_count++;
        end
    endtask

    task automatic check_reset_state(input string when_name);
        check_value({"cmd_valid ", when_name}, 0, cmd_valid);
        check_value({"req0_ready ", when_name}, 1, req0_ready);
        check_value({"req1_ready ", when_name}, 1, req1_ready);
    endtask

    task automatic check_transfer();
        burst_t want;
        int     ch;
        int     other;
        ch    = int'(cmd_channel);
        other = 1 - ch;
        // both channels busy, so the grant has to swap
        if (alternate_on && have_prev && prev_chan == cmd_channel && exp_q[other].size() > 0) begin
            check_value("alternating cmd_channel", other, ch);
        end
        have_prev = 1'b1;
        prev_chan = cmd_channel;
        if (exp_q[ch].size() == 0) begin
            $display("unexpected burst for channel %0d at address 0x%0h", ch, cmd_addr);
            error_count++;
        end else begin
            want = exp_q[ch].pop_front();
            check_value($sformatf("ch%0d burst %0d addr", ch, got_bursts[ch]), want.addr, cmd_addr);
            check_value($sformatf("ch%0d burst %0d len", ch, got_bursts[ch]), want.len, cmd_len);
            check_value($sformatf("ch%0d burst %0d last", ch, got_bursts[ch]), want.last, cmd_last);
            got_beats[ch] += int'(cmd_len) + LEN_OFFSET;
            got_bursts[ch]++;
            if (want.last) begin
                check_value($sformatf("ch%0d request beats", ch), exp_beats[ch].pop_front(),
                            got_beats[ch]);
                check_value($sformatf("ch%0d request bursts", ch), exp_bursts[ch].pop_front(),
                            got_bursts[ch]);
                got_beats[ch]  = 0;
                got_bursts[ch] = 0;
            end
        end
    endtask

    // ---------------------------------------------------------
    // back-pressure and bus monitor
    // ---------------------------------------------------------
    always @(posedge clk) begin
        lcg_state = lcg_next(lcg_state);
        cmd_ready <= (lcg_state[30:29] != 2'b00);
        if (!reset) begin
            // a new word on the bus, counted once
            if (cmd_valid && !bus_held && cmd_last) begin
                last_seen[cmd_channel]++;
            end
            for (int n = 0; n < NUM_CHANNELS; n++) begin
                if (req_ready_v[n] && accepted[n] != last_seen[n]) begin
                    check_value($sformatf("req%0d_ready before last burst on bus", n), 0, 1);
                end
                if (req_valid_v[n] && req_ready_v[n]) begin
                    accepted[n]++;
                end
            end
            if (cmd_valid && cmd_ready) begin
                check_transfer();
            end
            bus_held = cmd_valid && !cmd_ready;
        end
    end

    // ---------------------------------------------------------
    // main sequence
    // ---------------------------------------------------------
    initial begin
        reset         = 1'b1;
        cmd_ready     = 1'b0;
        req0_addr     = '0;
        req0_size     = '0;
        req0_max_len  = '0;
        req0_valid    = 1'b0;
        req1_addr     = '0;
        req1_size     = '0;
        req1_max_len  = '0;
        req1_valid    = 1'b0;
        lcg_state     = 32'd95;
        bus_held      = 1'b0;
        have_prev     = 1'b0;
        alternate_on  = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_reset_state("during reset");
            end
        end
        reset <= 1'b0;
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            check_reset_state("after reset");
        end
        for (int p = 0; p < NUM_PHASES; p++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (rows[r].phase == p) begin
                    row_q[rows[r].chan].push_back(rows[r]);
                    rows_per_chan[rows[r].chan]++;
                end
            end
            // one request per channel, started together
            alternate_on = (row_q[0].size() == 1) && (row_q[1].size() == 1);
            have_prev    = 1'b0;
            fork
                drive_channel(0);
                drive_channel(1);
            join
            wait_drained();
        end
        check_value("ch0 requests accepted", rows_per_chan[0], accepted[0]);
        check_value("ch1 requests accepted", rows_per_chan[1], accepted[1]);
        $display("value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 error_count, timeout_count, UUT.bus_props.assert_failures);
        if (error_count == 0 && timeout_count == 0 && UUT.bus_props.assert_failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
